// File: Makefile
VERILATOR ?= verilator
TOP       := tb_sram_testchip
FILELIST  := build.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert --top-module $(TOP) --Mdir $(OBJ_DIR)
LOG       := sim.log

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))
DATA := verification/testchip_tests.txt

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(SIM) $(DATA)
	./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi; \
	if [ $$status -ne 0 ]; then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: build.f
hw/sram_pkg.sv
hw/ctrl_pkg.sv
hw/scan_cmd_reg.sv
hw/apb_sram_bridge.sv
hw/sram_port_mux.sv
hw/sram_testchip_top.sv
verification/sram_testchip_assertions.sv
verification/tb_sram_testchip.sv

// File: hw/apb_sram_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module apb_sram_bridge #(
	parameter int          NUM_SRAMS = 4,
	parameter logic [31:0] APB_BASE  = 32'h3000_0000
) (
	input  wire                                  clk,
	input  wire                                  resetn,
	input  wire                                  psel_i,
	input  wire                                  penable_i,
	input  wire                                  pwrite_i,
	input  wire [31:0]                           paddr_i,
	input  wire sram_pkg::data_t                 pwdata_i,
	input  wire sram_pkg::wmask_t                pstrb_i,
	input  wire sram_pkg::data_t [NUM_SRAMS-1:0] sram_dout0_i,
	output ctrl_pkg::apb_req_t                   req_o,
	output sram_pkg::data_t                      prdata_o,
	output logic                                 pready_o,
	output logic                                 pslverr_o
);

	import ctrl_pkg::*;
	import sram_pkg::*;

	localparam logic [31:0] SPAN = NUM_SRAMS << WINDOW_BITS;	// bytes covered by all windows

	bridge_state_t state;
	bridge_state_t state_nxt;
	logic [31:0]   offset;
	logic          in_range;
	logic          req_valid;
	chip_sel_t     sel_q;
	logic          err_q;
	data_t         rd_data;

	assign offset   = paddr_i - APB_BASE;
	assign in_range = (paddr_i >= APB_BASE) && (offset < SPAN);

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (psel_i && !penable_i) begin	// setup phase
					state_nxt = ACCESS;
				end
			end
			ACCESS:  state_nxt = RESPOND;	// fixed single wait state
			RESPOND: state_nxt = IDLE;
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// an out-of-range address never reaches the srams
	assign req_valid = (state == ACCESS) && in_range;

	always_comb begin
		req_o.valid      = req_valid;
		req_o.sel        = offset[WINDOW_BITS +: SEL_WIDTH];
		req_o.port.addr  = offset[2 +: ADDR_WIDTH];	// word address inside the window
		req_o.port.din   = pwdata_i;
		req_o.port.csb   = !req_valid;
		req_o.port.web   = !pwrite_i;
		req_o.port.wmask = pstrb_i;
	end

	// decoded macro and error held for the response cycle
	always_ff @(posedge clk) begin
		if (state == ACCESS) begin
			sel_q <= req_o.sel;
			err_q <= !in_range;
		end
	end

	always_comb begin
		rd_data = '0;
		for (int i = 0; i < NUM_SRAMS; i++) begin
			if (sel_q == chip_sel_t'(i)) begin
				rd_data = sram_dout0_i[i];
			end
		end
	end

	assign pready_o  = (state == RESPOND);
	assign pslverr_o = pready_o && err_q;
	assign prdata_o  = (pready_o && !err_q) ? rd_data : '0;	// data valid one cycle after csb

endmodule

`default_nettype wire

// File: hw/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

	// each macro owns a 1 KiB window on the bus
	localparam int WINDOW_BITS = 10;

	// command word, chip index in the top bits so it leaves the scan chain first
	typedef struct packed {
		sram_pkg::chip_sel_t  sel;
		sram_pkg::sram_port_t port0;
		sram_pkg::sram_port_t port1;
	} cmd_t;

	localparam int CMD_WIDTH = $bits(cmd_t);

	// one port-0 access requested by the apb bridge
	typedef struct packed {
		logic                 valid;
		sram_pkg::chip_sel_t  sel;	// macro index from the window number
		sram_pkg::sram_port_t port;
	} apb_req_t;

	typedef enum logic [1:0] {
		IDLE,
		ACCESS,	// first penable cycle, request goes out
		RESPOND	// wait state done, pready high
	} bridge_state_t;

endpackage

`default_nettype wire

// File: hw/scan_cmd_reg.sv
`timescale 1ns/1ps
`default_nettype none

module scan_cmd_reg #(
	parameter int NUM_SRAMS = 4
) (
	input  wire                                  clk,
	input  wire                                  resetn,
	input  wire                                  gpio_scan_i,
	input  wire                                  gpio_in_i,	// serial bit into the lsb
	input  wire                                  la_load_i,
	input  wire ctrl_pkg::cmd_t                  la_data_i,
	input  wire                                  capture_i,
	input  wire sram_pkg::data_t [NUM_SRAMS-1:0] sram_dout0_i,
	input  wire sram_pkg::data_t [NUM_SRAMS-1:0] sram_dout1_i,
	output ctrl_pkg::cmd_t                       cmd_o,
	output logic                                 gpio_out_o
);

	import ctrl_pkg::*;
	import sram_pkg::*;

	cmd_t  cmd_q;
	data_t rd0;
	data_t rd1;

	// read data of the macro named in the word, zero past the last macro
	always_comb begin
		rd0 = '0;
		rd1 = '0;
		for (int i = 0; i < NUM_SRAMS; i++) begin
			if (cmd_q.sel == chip_sel_t'(i)) begin
				rd0 = sram_dout0_i[i];
				rd1 = sram_dout1_i[i];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			cmd_q <= '0;
		end else if (gpio_scan_i) begin
			cmd_q <= {cmd_q[CMD_WIDTH-2:0], gpio_in_i};	// shift toward the msb
		end else if (la_load_i) begin
			cmd_q <= la_data_i;
		end else if (capture_i) begin
			// only the din fields change, the rest of the word stays
			cmd_q.port0.din <= rd0;
			cmd_q.port1.din <= rd1;
		end
	end

	assign cmd_o      = cmd_q;
	assign gpio_out_o = cmd_q[CMD_WIDTH-1];	// bit that leaves the chain next

endmodule

`default_nettype wire

// File: hw/sram_pkg.sv
`default_nettype none

package sram_pkg;

	localparam int ADDR_WIDTH  = 8;	// words per macro port
	localparam int DATA_WIDTH  = 32;
	localparam int WMASK_WIDTH = 4;	// one enable per byte
	localparam int SEL_WIDTH   = 4;	// up to 16 macros

	typedef logic [ADDR_WIDTH-1:0]  addr_t;
	typedef logic [DATA_WIDTH-1:0]  data_t;
	typedef logic [WMASK_WIDTH-1:0] wmask_t;
	typedef logic [SEL_WIDTH-1:0]   chip_sel_t;

	// control of one shared sram port
	typedef struct packed {
		addr_t  addr;
		data_t  din;
		logic   csb;	// active low, before the per-macro decode
		logic   web;	// active low write
		wmask_t wmask;
	} sram_port_t;

endpackage

`default_nettype wire

// File: hw/sram_port_mux.sv
`timescale 1ns/1ps
`default_nettype none

module sram_port_mux #(
	parameter int NUM_SRAMS = 4
) (
	input  wire                     mode_select_i,	// 0 command word, 1 apb
	input  wire                     global_csb_i,
	input  wire ctrl_pkg::cmd_t     cmd_i,
	input  wire ctrl_pkg::apb_req_t req_i,
	output sram_pkg::sram_port_t    port0_o,
	output sram_pkg::sram_port_t    port1_o,
	output logic [NUM_SRAMS-1:0]    csb0_o,
	output logic [NUM_SRAMS-1:0]    csb1_o
);

	import sram_pkg::*;

	// a single low bit at the chip index when csb is asserted
	function automatic logic [NUM_SRAMS-1:0] csb_decode(chip_sel_t sel, logic csb);
		logic [NUM_SRAMS-1:0] dec;
		dec = '1;
		for (int i = 0; i < NUM_SRAMS; i++) begin
			if (!csb && (sel == chip_sel_t'(i))) begin
				dec[i] = 1'b0;
			end
		end
		return dec;
	endfunction

	always_comb begin
		port1_o = cmd_i.port1;	// port 1 always follows the command word
		if (mode_select_i) begin
			port0_o = req_i.port;
			csb0_o  = csb_decode(req_i.sel, !req_i.valid);
			csb1_o  = '1;	// port 1 disabled in bus mode
		end else begin
			port0_o = cmd_i.port0;
			// global_csb_i can hold every macro off
			csb0_o  = csb_decode(cmd_i.sel, global_csb_i | cmd_i.port0.csb);
			csb1_o  = csb_decode(cmd_i.sel, global_csb_i | cmd_i.port1.csb);
		end
		// select travels on the per-macro vectors only
		port0_o.csb = 1'b1;
		port1_o.csb = 1'b1;
	end

endmodule

`default_nettype wire

// File: hw/sram_testchip_top.sv
`timescale 1ns/1ps
`default_nettype none

module sram_testchip_top #(
	parameter int          NUM_SRAMS = 4,
	parameter logic [31:0] APB_BASE  = 32'h3000_0000
) (
	input  wire                                  clk,
	input  wire                                  resetn,
	input  wire                                  mode_select_i,
	input  wire                                  global_csb_i,
	input  wire                                  gpio_scan_i,
	input  wire                                  gpio_in_i,
	input  wire                                  capture_i,
	input  wire                                  la_load_i,
	input  wire ctrl_pkg::cmd_t                  la_data_i,
	// apb slave
	input  wire                                  psel_i,
	input  wire                                  penable_i,
	input  wire                                  pwrite_i,
	input  wire [31:0]                           paddr_i,
	input  wire sram_pkg::data_t                 pwdata_i,
	input  wire sram_pkg::wmask_t                pstrb_i,
	output sram_pkg::data_t                      prdata_o,
	output logic                                 pready_o,
	output logic                                 pslverr_o,
	// shared sram ports, one csb per macro
	input  wire sram_pkg::data_t [NUM_SRAMS-1:0] sram_dout0_i,
	input  wire sram_pkg::data_t [NUM_SRAMS-1:0] sram_dout1_i,
	output sram_pkg::sram_port_t                 port0_o,
	output sram_pkg::sram_port_t                 port1_o,
	output logic [NUM_SRAMS-1:0]                 csb0_o,
	output logic [NUM_SRAMS-1:0]                 csb1_o,
	output ctrl_pkg::cmd_t                       la_data_o,
	output logic                                 gpio_out_o
);

	import ctrl_pkg::*;

	cmd_t     cmd;
	apb_req_t req;

	scan_cmd_reg #(.NUM_SRAMS(NUM_SRAMS)) u_cmd_reg (
		.clk          (clk),
		.resetn       (resetn),
		.gpio_scan_i  (gpio_scan_i),
		.gpio_in_i    (gpio_in_i),
		.la_load_i    (la_load_i),
		.la_data_i    (la_data_i),
		.capture_i    (capture_i),
		.sram_dout0_i (sram_dout0_i),
		.sram_dout1_i (sram_dout1_i),
		.cmd_o        (cmd),
		.gpio_out_o   (gpio_out_o)
	);

	apb_sram_bridge #(
		.NUM_SRAMS (NUM_SRAMS),
		.APB_BASE  (APB_BASE)
	) u_bridge (
		.clk          (clk),
		.resetn       (resetn),
		.psel_i       (psel_i),
		.penable_i    (penable_i),
		.pwrite_i     (pwrite_i),
		.paddr_i      (paddr_i),
		.pwdata_i     (pwdata_i),
		.pstrb_i      (pstrb_i),
		.sram_dout0_i (sram_dout0_i),
		.req_o        (req),
		.prdata_o     (prdata_o),
		.pready_o     (pready_o),
		.pslverr_o    (pslverr_o)
	);

	sram_port_mux #(.NUM_SRAMS(NUM_SRAMS)) u_mux (
		.mode_select_i (mode_select_i),
		.global_csb_i  (global_csb_i),
		.cmd_i         (cmd),
		.req_i         (req),
		.port0_o       (port0_o),
		.port1_o       (port1_o),
		.csb0_o        (csb0_o),
		.csb1_o        (csb1_o)
	);

	assign la_data_o = cmd;	// logic analyzer sees the live command word

endmodule

`default_nettype wire

// File: verification/sram_testchip_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module sram_testchip_assertions #(
	parameter int NUM_SRAMS = 4
) (
	input wire                 clk,
	input wire                 resetn,
	input wire                 mode_select_i,
	input wire [NUM_SRAMS-1:0] csb0_i,
	input wire [NUM_SRAMS-1:0] csb1_i,
	input wire                 req_valid_i,	// bridge request to the mux
	input wire                 pready_i,
	input wire                 pslverr_i
);

	// one macro at most per port
	assert property (@(posedge clk) disable iff (!resetn) $onehot0(~csb0_i))
		else $error("more than one port 0 chip select is low");
	assert property (@(posedge clk) disable iff (!resetn) $onehot0(~csb1_i))
		else $error("more than one port 1 chip select is low");

	// port 1 is off while the bus owns port 0
	assert property (@(posedge clk) disable iff (!resetn) mode_select_i |-> (&csb1_i))
		else $error("port 1 chip select low in bus mode");

	assert property (@(posedge clk) disable iff (!resetn) pready_i |=> !pready_i)
		else $error("pready held high for more than one cycle");

	// a good response comes one cycle after the request
	assert property (@(posedge clk) disable iff (!resetn)
		(pready_i && !pslverr_i) |-> $past(req_valid_i))
		else $error("pready without a valid request in the cycle before");

endmodule

bind sram_testchip_top sram_testchip_assertions #(.NUM_SRAMS(NUM_SRAMS)) u_checks (
	.clk           (clk),
	.resetn        (resetn),
	.mode_select_i (mode_select_i),
	.csb0_i        (csb0_o),
	.csb1_i        (csb1_o),
	.req_valid_i   (req.valid),
	.pready_i      (pready_o),
	.pslverr_i     (pslverr_o)
);

`default_nettype wire

// File: verification/tb_sram_testchip.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sram_testchip;

	import ctrl_pkg::*;
	import sram_pkg::*;

	localparam int          NUM_SRAMS = 4;
	localparam logic [31:0] APB_BASE  = 32'h3000_0000;
	localparam int          MAX_REC   = 64;
	localparam int          OP_LOAD    = 0;
	localparam int          OP_SCAN    = 1;
	localparam int          OP_CAPTURE = 2;
	localparam int          OP_APB_WR  = 3;
	localparam int          OP_APB_RD  = 4;

	logic clk, resetn, mode_select, global_csb, gpio_scan, gpio_in, capture, la_load;
	cmd_t la_data;
	logic psel, penable, pwrite;
	logic [31:0] paddr;
	data_t pwdata;
	wmask_t pstrb;
	data_t prdata;
	logic pready, pslverr;
	data_t [NUM_SRAMS-1:0] dout0;
	data_t [NUM_SRAMS-1:0] dout1;
	sram_port_t port0, port1;
	logic [NUM_SRAMS-1:0] csb0, csb1;
	cmd_t la_data_out;
	logic gpio_out;

	// read data model with one word per macro and port
	data_t mem0 [NUM_SRAMS];
	data_t mem1 [NUM_SRAMS];
	logic [NUM_SRAMS-1:0] csb0_q = '1;
	logic [NUM_SRAMS-1:0] csb1_q = '1;

	int rec_op [MAX_REC];
	logic [127:0] rec_arg [MAX_REC][6];
	int num_records = 0;
	logic tests_loaded = 1'b0;
	int error_count = 0;
	int check_count = 0;
	cmd_t cmd_exp;	// expected command word

	sram_testchip_top #(.NUM_SRAMS(NUM_SRAMS), .APB_BASE(APB_BASE)) DUT (
		.clk (clk), .resetn (resetn), .mode_select_i (mode_select),
		.global_csb_i (global_csb), .gpio_scan_i (gpio_scan), .gpio_in_i (gpio_in),
		.capture_i (capture), .la_load_i (la_load), .la_data_i (la_data),
		.psel_i (psel), .penable_i (penable), .pwrite_i (pwrite), .paddr_i (paddr),
		.pwdata_i (pwdata), .pstrb_i (pstrb), .prdata_o (prdata), .pready_o (pready),
		.pslverr_o (pslverr), .sram_dout0_i (dout0), .sram_dout1_i (dout1),
		.port0_o (port0), .port1_o (port1), .csb0_o (csb0), .csb1_o (csb1),
		.la_data_o (la_data_out), .gpio_out_o (gpio_out)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		csb0_q <= csb0;
		csb1_q <= csb1;
	end

	// data is there while csb is low and one cycle after
	always_comb begin
		for (int i = 0; i < NUM_SRAMS; i++) begin
			dout0[i] = (!csb0[i] || !csb0_q[i]) ? mem0[i] : '0;
			dout1[i] = (!csb1[i] || !csb1_q[i]) ? mem1[i] : '0;
		end
	end

	task automatic check_value(input string name, input logic [127:0] got,
			input logic [127:0] exp);
		check_count++;
		if (got !== exp) begin
			$display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
			error_count++;
		end
	endtask

	task automatic check_port(input string name, input sram_port_t got, input sram_port_t exp);
		check_value({name, ".addr"}, got.addr, exp.addr);
		check_value({name, ".din"}, got.din, exp.din);
		check_value({name, ".web"}, got.web, exp.web);
		check_value({name, ".wmask"}, got.wmask, exp.wmask);
		check_value({name, ".csb"}, got.csb, 1'b1);
	endtask

	task automatic wait_drive();
		@(posedge clk);
		#2;
	endtask

	task automatic randomize_read_data();
		for (int i = 0; i < NUM_SRAMS; i++) begin
			mem0[i] = $urandom;
			mem1[i] = $urandom;
		end
	endtask

	task automatic read_tests();
		int fd;
		int n;
		string line;
		string op;
		logic [127:0] v [6];
		fd = $fopen("verification/testchip_tests.txt", "r");
		if (fd == 0) begin
			$display("could not open the test file");
			error_count++;
			return;
		end
		while (!$feof(fd) && num_records < MAX_REC) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line[0] == "#") continue;	// blank or comment
			n = $sscanf(line, "%s %h %h %h %h %h %h", op, v[0], v[1], v[2], v[3], v[4], v[5]);
			if (n != 7) begin
				$display("malformed record in the test file: %s", line);
				error_count++;
				continue;
			end
			if (op == "LOAD") rec_op[num_records] = OP_LOAD;
			else if (op == "SCAN") rec_op[num_records] = OP_SCAN;
			else if (op == "CAPTURE") rec_op[num_records] = OP_CAPTURE;
			else if (op == "APB_WR") rec_op[num_records] = OP_APB_WR;
			else if (op == "APB_RD") rec_op[num_records] = OP_APB_RD;
			else begin
				$display("unknown opcode %s in the test file", op);
				error_count++;
				continue;
			end
			for (int k = 0; k < 6; k++) rec_arg[num_records][k] = v[k];
			num_records++;
		end
		$fclose(fd);
		if (num_records == 0) begin
			$display("the test file holds no records");
			error_count++;
		end
	endtask

	task automatic do_load(input int r);
		cmd_exp = {rec_arg[r][0][3:0], rec_arg[r][1][45:0], rec_arg[r][2][45:0]};
		mode_select = 1'b0;
		global_csb  = rec_arg[r][3][0];
		la_data     = cmd_exp;
		la_load     = 1'b1;
		wait_drive();
		la_load = 1'b0;
		@(negedge clk);
		check_value("la_data_o", la_data_out, cmd_exp);
		check_port("port0_o", port0, cmd_exp.port0);
		check_port("port1_o", port1, cmd_exp.port1);
		check_value("csb0_o", csb0, rec_arg[r][4][NUM_SRAMS-1:0]);
		check_value("csb1_o", csb1, rec_arg[r][5][NUM_SRAMS-1:0]);
		wait_drive();
	endtask

	task automatic do_scan(input int r);
		logic b;
		for (int i = 0; i < int'(rec_arg[r][0][15:0]); i++) begin
			b = 1'($urandom);
			gpio_scan = 1'b1;
			gpio_in   = b;
			cmd_exp   = {cmd_exp[CMD_WIDTH-2:0], b};
			wait_drive();
		end
		gpio_scan = 1'b0;
		gpio_in   = 1'b0;
		@(negedge clk);
		check_value("la_data_o", la_data_out, cmd_exp);
		check_value("gpio_out_o", gpio_out, cmd_exp[CMD_WIDTH-1]);
		wait_drive();
	endtask

	task automatic do_capture(input int r);
		randomize_read_data();
		if (cmd_exp.sel < NUM_SRAMS) begin
			mem0[cmd_exp.sel] = rec_arg[r][0][31:0];
			mem1[cmd_exp.sel] = rec_arg[r][1][31:0];
		end
		capture = 1'b1;
		wait_drive();
		capture = 1'b0;
		cmd_exp.port0.din = rec_arg[r][3][31:0];
		cmd_exp.port1.din = rec_arg[r][4][31:0];
		@(negedge clk);
		check_value("la_data_o", la_data_out, cmd_exp);
		wait_drive();
	endtask

	// counts cycles from the first penable cycle up to the pready negedge
	task automatic wait_ready(output int cycles);
		cycles = 1;
		while (!pready && cycles < 8) begin
			@(negedge clk);
			cycles++;
		end
		if (!pready) begin
			$display("pready never came back from the APB bridge");
			error_count++;
		end
	endtask

	task automatic apb_setup(input logic write, input logic [31:0] addr, input data_t wdata,
			input wmask_t strb);
		mode_select = 1'b1;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = write;
		paddr   = addr;
		pwdata  = wdata;
		pstrb   = strb;
		wait_drive();
		penable = 1'b1;
		@(negedge clk);
	endtask

	task automatic apb_finish();
		wait_drive();
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic do_apb_write(input int r);
		int cycles;
		randomize_read_data();
		apb_setup(1'b1, rec_arg[r][0][31:0], rec_arg[r][1][31:0], rec_arg[r][2][3:0]);
		check_value("csb0_o", csb0, rec_arg[r][4][NUM_SRAMS-1:0]);
		check_value("csb1_o", csb1, {NUM_SRAMS{1'b1}});
		check_value("port0_o.addr", port0.addr, rec_arg[r][5][7:0]);
		check_value("port0_o.din", port0.din, rec_arg[r][1][31:0]);
		check_value("port0_o.web", port0.web, 1'b0);
		check_value("port0_o.wmask", port0.wmask, rec_arg[r][2][3:0]);
		check_port("port1_o", port1, cmd_exp.port1);	// port 1 stays on the command word
		wait_ready(cycles);
		check_value("pready_o latency", cycles, 2);
		check_value("csb0_o", csb0, {NUM_SRAMS{1'b1}});	// request gone in the wait state
		apb_finish();
	endtask

	task automatic do_apb_read(input int r);
		int cycles;
		logic [31:0] offset;
		randomize_read_data();
		offset = rec_arg[r][0][31:0] - APB_BASE;
		if (rec_arg[r][0][31:0] >= APB_BASE && (offset >> 10) < NUM_SRAMS) begin
			mem0[offset >> 10] = rec_arg[r][1][31:0];
		end
		apb_setup(1'b0, rec_arg[r][0][31:0], '0, '0);
		check_value("csb0_o", csb0, rec_arg[r][5][NUM_SRAMS-1:0]);
		check_value("csb1_o", csb1, {NUM_SRAMS{1'b1}});
		wait_ready(cycles);
		check_value("pready_o latency", cycles, 2);
		check_value("csb0_o", csb0, {NUM_SRAMS{1'b1}});
		check_value("prdata_o", prdata, rec_arg[r][3][31:0]);
		check_value("pslverr_o", pslverr, rec_arg[r][4][0]);
		apb_finish();
	endtask

	initial begin
		wait (tests_loaded);
		repeat (num_records * 200 + 12) @(posedge clk);
		$display("the run timed out before all test records were done");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		void'($urandom(32'h95f3));
		resetn = 1'b0;
		mode_select = 1'b0;
		global_csb = 1'b1;	// keeps every macro off during reset
		gpio_scan = 1'b0;
		gpio_in = 1'b0;
		capture = 1'b0;
		la_load = 1'b0;
		la_data = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		pstrb = '0;
		cmd_exp = '0;
		randomize_read_data();
		read_tests();
		tests_loaded = 1'b1;
		repeat (8) @(posedge clk);
		#2;
		resetn = 1'b1;
		@(negedge clk);
		check_value("csb0_o", csb0, {NUM_SRAMS{1'b1}});
		check_value("csb1_o", csb1, {NUM_SRAMS{1'b1}});
		check_value("pready_o", pready, 1'b0);
		wait_drive();
		for (int r = 0; r < num_records; r++) begin
			case (rec_op[r])
				OP_LOAD:    do_load(r);
				OP_SCAN:    do_scan(r);
				OP_CAPTURE: do_capture(r);
				OP_APB_WR:  do_apb_write(r);
				default:    do_apb_read(r);
			endcase
		end
		wait_drive();
		$display("records: %0d checks: %0d errors: %0d", num_records, check_count, error_count);
		if (error_count == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/testchip_tests.txt
# op       a        b              c              d         e         f
# LOAD     sel      port0 (46b)    port1 (46b)    gcsb      csb0      csb1
# SCAN     nbits    -              -              -         -         -
# CAPTURE  rd0      rd1            -              din0      din1      -
# APB_WR   paddr    pwdata         pstrb          -         csb0      addr
# APB_RD   paddr    word           -              prdata    pslverr   csb0
LOAD 2 16848d159e1f cf2bfbc0343 0 b b
LOAD 2 16848d159e1f cf2bfbc0343 1 f f
LOAD 2 16848d159e3f cf2bfbc0343 0 f b
LOAD 1 16848d159e1f cf2bfbc0363 0 d f
SCAN a 0 0 0 0 0
SCAN 7 0 0 0 0 0
LOAD 2 16848d159e1f cf2bfbc0343 0 b b
CAPTURE 11112222 33334444 0 11112222 33334444 0
APB_WR 30000808 a5a5a5a5 6 0 b 2
APB_WR 30000c40 0badf00d f 0 7 10
APB_RD 30000404 deadbeef 0 deadbeef 0 d
APB_RD 30001000 12121212 0 0 1 f
